// File: all.f
+incdir+design
design/par_pkg.sv
design/gc_dispatch.sv
design/loop_core.sv
design/fork_ctrl.sv
design/par_loop_top.sv
testbench/tb_par_loop.sv

// File: design/fork_ctrl.sv
`timescale 1ns/1ps
`include "par_macros.svh"

module fork_ctrl (
	input logic clk,
	input logic arst_n,
	input par_pkg::wb_req_t wb_req,
	output par_pkg::wb_rsp_t wb_rsp,
	output logic fork_go,
	output par_pkg::fork_cmd_t fork_cmd,
	input logic ending [`N_CORE],
	input logic [`ACC_WIDTH-1:0] partial [`N_CORE]
);

	par_pkg::ctrl_state_t state;
	logic signed [`GC_WIDTH-1:0] start_r;
	logic signed [`GC_WIDTH-1:0] stride_r;
	logic signed [`GC_WIDTH-1:0] bound_r;
	logic [`ACC_WIDTH-1:0] result;
	logic [`ACC_WIDTH-1:0] sum_partial;
	logic [`ACC_WIDTH-1:0] rdata;
	logic ack_q;
	logic wb_hit;
	logic wr_en;
	logic start_req;
	logic launch;
	logic done;
	logic busy;
	logic all_ending;

	function automatic logic [`ACC_WIDTH-1:0] sext(input logic [`GC_WIDTH-1:0] v);
		sext = {{(`ACC_WIDTH-`GC_WIDTH){v[`GC_WIDTH-1]}}, v};
	endfunction

	assign wb_hit = wb_req.cyc && wb_req.stb;
	assign wr_en = wb_rsp.ack && wb_req.we;
	assign start_req = wr_en && (wb_req.adr == `REG_CTRL) && wb_req.dat[0];
	// Only a nonzero stride actually forks
	assign launch = start_req && (state == par_pkg::READY) && (stride_r != '0);
	assign busy = (state != par_pkg::READY);

	always_comb begin
		all_ending = 1'b1;
		sum_partial = '0;
		for (int i = 0; i < `N_CORE; i++) begin
			all_ending = all_ending && ending[i];
			sum_partial = sum_partial + partial[i];
		end
	end

	always_comb begin
		case (wb_req.adr)
			`REG_START: rdata = sext(start_r);
			`REG_STRIDE: rdata = sext(stride_r);
			`REG_BOUND: rdata = sext(bound_r);
			`REG_STATUS: rdata = {{(`ACC_WIDTH-2){1'b0}}, done, busy};
			`REG_RESULT: rdata = result;
			default: rdata = '0;
		endcase
	end

	// Ack drops as soon as the master lets go
	assign wb_rsp.ack = ack_q && wb_hit;
	assign wb_rsp.dat = rdata;

	// Loop description frozen until the next fork
	always_ff @(posedge clk) begin
		if (launch) begin
			fork_cmd.start <= start_r;
			fork_cmd.stride <= stride_r;
			fork_cmd.bound <= bound_r;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= par_pkg::READY;
			ack_q <= 1'b0;
			fork_go <= 1'b0;
			done <= 1'b0;
			result <= '0;
			start_r <= '0;
			stride_r <= '0;
			bound_r <= '0;
		end else begin
			ack_q <= wb_hit && !ack_q;
			fork_go <= launch;
			if (wr_en) begin
				case (wb_req.adr)
					`REG_START: start_r <= wb_req.dat[`GC_WIDTH-1:0];
					`REG_STRIDE: stride_r <= wb_req.dat[`GC_WIDTH-1:0];
					`REG_BOUND: bound_r <= wb_req.dat[`GC_WIDTH-1:0];
					default: ;
				endcase
			end
			case (state)
				par_pkg::READY: begin
					if (launch) begin
						done <= 1'b0;
						state <= par_pkg::RUN;
					end else if (start_req) begin
						// Empty loop, done at once
						done <= 1'b1;
						result <= '0;
					end
				end
				par_pkg::RUN: begin
					// First RUN cycle still sees the old ending bits
					if (!fork_go && all_ending) begin
						state <= par_pkg::REDUCE;
					end
				end
				par_pkg::REDUCE: begin
					result <= sum_partial;
					done <= 1'b1;
					state <= par_pkg::READY;
				end
				default: begin
					state <= par_pkg::READY;
				end
			endcase
		end
	end

	// Master holds its request steady until ack
	a_req_held: assert property (
		@(posedge clk) disable iff (!arst_n)
		(wb_hit && !wb_rsp.ack) |=> (wb_hit && $stable(wb_req))
	) else $error("fork_ctrl: Wishbone request dropped or changed before ack");

endmodule

// File: design/gc_dispatch.sv
`timescale 1ns/1ps
`include "par_macros.svh"

module gc_dispatch (
	input logic clk,
	input logic arst_n,
	input logic fork_go,
	input par_pkg::fork_cmd_t fork_cmd,
	input logic claim [`N_CORE],
	output logic signed [`GC_WIDTH-1:0] index [`N_CORE]
);

	localparam int CNT_W = $clog2(`N_CORE + 1);

	logic signed [`GC_WIDTH-1:0] gc;
	logic signed [`GC_WIDTH-1:0] gd;
	logic [`N_CORE-1:0] claim_vec;
	// Counter plus k strides, k = 0 .. N_CORE
	logic signed [`GC_WIDTH-1:0] gc_plus [`N_CORE+1];
	// Number of claims from cores below i
	logic [CNT_W-1:0] prefix [`N_CORE+1];

	always_comb begin
		for (int i = 0; i < `N_CORE; i++) begin
			claim_vec[i] = claim[i];
		end
	end

	// Chained adders instead of multipliers
	always_comb begin
		gc_plus[0] = gc;
		for (int k = 0; k < `N_CORE; k++) begin
			gc_plus[k+1] = gc_plus[k] + gd;
		end
	end

	always_comb begin
		prefix[0] = '0;
		for (int i = 0; i < `N_CORE; i++) begin
			prefix[i+1] = prefix[i] + {{(CNT_W-1){1'b0}}, claim_vec[i]};
		end
	end

	// Grant in the claim cycle, distinct per claiming core
	always_comb begin
		for (int i = 0; i < `N_CORE; i++) begin
			index[i] = gc_plus[prefix[i]];
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			gc <= '0;
			gd <= '0;
		end else if (fork_go) begin
			gc <= fork_cmd.start;
			gd <= fork_cmd.stride;
		end else begin
			// Advance by one stride per claim served
			gc <= gc_plus[prefix[`N_CORE]];
		end
	end

	// Cores must be idle or ending when the parent forks
	a_fork_no_claim: assert property (
		@(posedge clk) disable iff (!arst_n)
		fork_go |-> (claim_vec == '0)
	) else $error("gc_dispatch: claim during fork_go, claim=%b", claim_vec);

endmodule

// File: design/loop_core.sv
`timescale 1ns/1ps
`include "par_macros.svh"

module loop_core (
	input logic clk,
	input logic arst_n,
	input logic fork_go,
	input par_pkg::fork_cmd_t fork_cmd,
	output logic claim,
	input logic signed [`GC_WIDTH-1:0] index,
	output logic ending,
	output logic [`ACC_WIDTH-1:0] partial
);

	par_pkg::core_state_t state;
	logic [1:0] wait_cnt;
	logic signed [`GC_WIDTH-1:0] cur_idx;
	logic signed [`ACC_WIDTH-1:0] square;
	logic in_range;

	assign claim = (state == par_pkg::CLAIM);
	assign ending = (state == par_pkg::ENDING);

	// Bound test follows the stride direction, zero stride is empty
	always_comb begin
		if (fork_cmd.stride[`GC_WIDTH-1]) begin
			in_range = $signed(index) > $signed(fork_cmd.bound);
		end else if (fork_cmd.stride != '0) begin
			in_range = $signed(index) < $signed(fork_cmd.bound);
		end else begin
			in_range = 1'b0;
		end
	end

	// Operands widen to 32 bits before the multiply
	assign square = cur_idx * cur_idx;

	// Index taken in the claim cycle
	always_ff @(posedge clk) begin
		if (claim) begin
			cur_idx <= index;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= par_pkg::IDLE;
			wait_cnt <= '0;
			partial <= '0;
		end else begin
			case (state)
				par_pkg::IDLE, par_pkg::ENDING: begin
					if (fork_go) begin
						state <= par_pkg::CLAIM;
						partial <= '0;
					end
				end
				par_pkg::CLAIM: begin
					if (in_range) begin
						// Work time is low index bits plus one
						wait_cnt <= index[1:0];
						state <= par_pkg::WORK;
					end else begin
						state <= par_pkg::ENDING;
					end
				end
				par_pkg::WORK: begin
					if (wait_cnt == 2'd0) begin
						partial <= partial + square;
						state <= par_pkg::CLAIM;
					end else begin
						wait_cnt <= wait_cnt - 2'd1;
					end
				end
				default: begin
					state <= par_pkg::IDLE;
				end
			endcase
		end
	end

	// Parent forks only while the core is free
	a_fork_when_free: assert property (
		@(posedge clk) disable iff (!arst_n)
		fork_go |-> (state == par_pkg::IDLE || state == par_pkg::ENDING)
	) else $error("loop_core: fork_go while the core is still working");

endmodule

// File: design/par_loop_top.sv
`timescale 1ns/1ps
`include "par_macros.svh"

module par_loop_top (
	input logic clk,
	input logic arst_n,
	input par_pkg::wb_req_t wb_req,
	output par_pkg::wb_rsp_t wb_rsp
);

	logic fork_go;
	par_pkg::fork_cmd_t fork_cmd;
	logic claim [`N_CORE];
	logic signed [`GC_WIDTH-1:0] index [`N_CORE];
	logic ending [`N_CORE];
	logic [`ACC_WIDTH-1:0] partial [`N_CORE];

	// Parent with the register block
	fork_ctrl u_fork_ctrl (
		.clk(clk),
		.arst_n(arst_n),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.fork_go(fork_go),
		.fork_cmd(fork_cmd),
		.ending(ending),
		.partial(partial)
	);

	// Shared index counter
	gc_dispatch u_gc_dispatch (
		.clk(clk),
		.arst_n(arst_n),
		.fork_go(fork_go),
		.fork_cmd(fork_cmd),
		.claim(claim),
		.index(index)
	);

	// Workers, lower numbers win the lower indices in a shared cycle
	for (genvar i = 0; i < `N_CORE; i++) begin : g_core
		loop_core u_core (
			.clk(clk),
			.arst_n(arst_n),
			.fork_go(fork_go),
			.fork_cmd(fork_cmd),
			.claim(claim[i]),
			.index(index[i]),
			.ending(ending[i]),
			.partial(partial[i])
		);
	end

endmodule

// File: design/par_macros.svh
`ifndef PAR_MACROS_SVH
`define PAR_MACROS_SVH

// Core count and datapath widths
`define N_CORE 4
`define GC_WIDTH 16
`define ACC_WIDTH 32

// Wishbone word addresses
`define REG_START 3'd0
`define REG_STRIDE 3'd1
`define REG_BOUND 3'd2
`define REG_CTRL 3'd3
`define REG_STATUS 3'd4
`define REG_RESULT 3'd5

`endif

// File: design/par_pkg.sv
`include "par_macros.svh"

package par_pkg;

	// Wishbone classic request, master to slave
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [2:0] adr;
		logic [`ACC_WIDTH-1:0] dat;
	} wb_req_t;

	// Wishbone classic response, slave to master
	typedef struct packed {
		logic [`ACC_WIDTH-1:0] dat;
		logic ack;
	} wb_rsp_t;

	// Loop description sent to dispatcher and cores at a fork
	typedef struct packed {
		logic signed [`GC_WIDTH-1:0] start;
		logic signed [`GC_WIDTH-1:0] stride;
		logic signed [`GC_WIDTH-1:0] bound;
	} fork_cmd_t;

	// Worker FSM
	typedef enum logic [1:0] {
		IDLE,
		CLAIM,
		WORK,
		ENDING
	} core_state_t;

	// Parent FSM
	typedef enum logic [1:0] {
		READY,
		RUN,
		REDUCE
	} ctrl_state_t;

endpackage

// File: testbench/tb_par_loop.sv
`timescale 1ns/1ps
`include "par_macros.svh"

module tb_par_loop;

	localparam int ACK_LIMIT = 8;
	localparam int POLL_LIMIT = 256 * 5 + 100;
	// 20 loops of up to 256 indices, at most 5 cycles each, plus bus overhead
	localparam int WATCHDOG_CYCLES = 20 * (256 * 5 + 100);

	logic clk;
	logic arst_n;
	par_pkg::wb_req_t wb_req;
	par_pkg::wb_rsp_t wb_rsp;

	// Pending checks, filled by the stimulus and drained by the comparing process
	string name_q[$];
	logic [`ACC_WIDTH-1:0] exp_q[$];
	logic [`ACC_WIDTH-1:0] act_q[$];
	int pass_count = 0;
	int fail_count = 0;
	logic [31:0] lcg_state = 32'he23;

	par_loop_top dut (.clk(clk), .arst_n(arst_n), .wb_req(wb_req), .wb_rsp(wb_rsp));

	initial clk = 1'b0;
	always #50 clk = ~clk;

	function automatic logic [31:0] next_random(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Walks the loop rule, sum of squares modulo 2^32
	function automatic logic [`ACC_WIDTH-1:0] expected_sum(
			input logic signed [`GC_WIDTH-1:0] start,
			input logic signed [`GC_WIDTH-1:0] stride,
			input logic signed [`GC_WIDTH-1:0] bound);
		int idx;
		int step;
		int lim;
		logic [`ACC_WIDTH-1:0] sum;
		idx = start;
		step = stride;
		lim = bound;
		sum = '0;
		if (step == 0) begin
			return sum;
		end
		while ((step > 0) ? (idx < lim) : (idx > lim)) begin
			sum = sum + idx * idx;
			idx = idx + step;
		end
		return sum;
	endfunction

	task automatic bus_access(input logic write, input logic [2:0] adr, input logic [31:0] wdat,
			output logic [31:0] rdat);
		par_pkg::wb_req_t req;
		int waited;
		req = '0;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we = write;
		req.adr = adr;
		req.dat = wdat;
		waited = 0;
		@(posedge clk);
		wb_req <= req;
		// Ack and read data are sampled mid-cycle
		do begin
			@(negedge clk);
			waited++;
		end while (!wb_rsp.ack && waited < ACK_LIMIT);
		assert (wb_rsp.ack) else begin
			$display("No Wishbone ack at address %0d within %0d cycles", adr, ACK_LIMIT);
			fail_count++;
		end
		rdat = wb_rsp.dat;
		@(posedge clk);
		wb_req <= '0;
	endtask

	task automatic write_reg(input logic [2:0] adr, input logic [31:0] wdat);
		logic [31:0] ignored;
		bus_access(1'b1, adr, wdat, ignored);
	endtask

	task automatic read_reg(input logic [2:0] adr, output logic [31:0] rdat);
		bus_access(1'b0, adr, 32'd0, rdat);
	endtask

	task automatic expect_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		name_q.push_back(name);
		exp_q.push_back(exp);
		act_q.push_back(act);
	endtask

	task automatic report_test(input string name, input int fails_before);
		wait (act_q.size() == 0);
		if (fail_count == fails_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, fail_count - fails_before);
		end
	endtask

	task automatic run_loop(input string name, input int start, input int stride, input int bound,
			input bit check_busy, input bit restart_busy);
		logic signed [`GC_WIDTH-1:0] s16;
		logic signed [`GC_WIDTH-1:0] d16;
		logic signed [`GC_WIDTH-1:0] b16;
		logic [31:0] status;
		logic [31:0] result;
		int polls;
		int fails_before;
		s16 = start;
		d16 = stride;
		b16 = bound;
		fails_before = fail_count;
		write_reg(`REG_START, start);
		write_reg(`REG_STRIDE, stride);
		write_reg(`REG_BOUND, bound);
		write_reg(`REG_CTRL, 32'd1);
		read_reg(`REG_STATUS, status);
		if (check_busy) begin
			// Busy set and done cleared by the start
			expect_value("STATUS", 32'd1, status);
		end
		if (restart_busy) begin
			// A restart taken now would fork from the new start
			write_reg(`REG_START, start + 5);
			write_reg(`REG_CTRL, 32'd1);
		end
		polls = 0;
		while (!status[1] && polls < POLL_LIMIT) begin
			read_reg(`REG_STATUS, status);
			polls++;
		end
		assert (status[1]) else begin
			$display("Loop %s did not report done after %0d status reads", name, polls);
			fail_count++;
		end
		expect_value("STATUS", 32'd2, status);
		if (restart_busy) begin
			// A second accepted start would show busy again here
			repeat (20) @(posedge clk);
			read_reg(`REG_STATUS, status);
			expect_value("STATUS", 32'd2, status);
		end
		read_reg(`REG_RESULT, result);
		expect_value("RESULT", expected_sum(s16, d16, b16), result);
		report_test(name, fails_before);
	endtask

	// Comparing process
	initial begin
		string name;
		logic [31:0] exp_v;
		logic [31:0] act_v;
		forever begin
			wait (act_q.size() != 0);
			name = name_q.pop_front();
			exp_v = exp_q.pop_front();
			act_v = act_q.pop_front();
			assert (act_v === exp_v) pass_count++;
			else begin
				$display("[FAIL] %s: expected 0x%08h, got 0x%08h", name, exp_v, act_v);
				fail_count++;
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		logic [31:0] rdata;
		int fails_before;
		int start;
		int stride;
		int bound;
		int mag;
		int count;
		int tmp;
		arst_n = 1'b0;
		wb_req = '0;
		repeat (8) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);

		fails_before = fail_count;
		read_reg(`REG_STATUS, rdata);
		expect_value("STATUS", 32'd0, rdata);
		read_reg(`REG_RESULT, rdata);
		expect_value("RESULT", 32'd0, rdata);
		// Upper half dropped, bit 15 extended on read
		write_reg(`REG_START, 32'h0000_8123);
		write_reg(`REG_STRIDE, 32'h1234_5678);
		write_reg(`REG_BOUND, 32'habcd_fffe);
		read_reg(`REG_START, rdata);
		expect_value("START", 32'hffff_8123, rdata);
		read_reg(`REG_STRIDE, rdata);
		expect_value("STRIDE", 32'h0000_5678, rdata);
		read_reg(`REG_BOUND, rdata);
		expect_value("BOUND", 32'hffff_fffe, rdata);
		read_reg(`REG_CTRL, rdata);
		expect_value("CTRL", 32'd0, rdata);
		report_test("register readback", fails_before);

		run_loop("positive stride", 3, 2, 40, 1'b1, 1'b0);
		// 19 indices, not a multiple of the core count
		run_loop("negative stride", 50, -3, -7, 1'b1, 1'b0);
		run_loop("zero stride", 5, 0, 100, 1'b0, 1'b0);
		run_loop("start past bound", 100, 4, 10, 1'b0, 1'b0);
		run_loop("start while busy", 0, 1, 200, 1'b1, 1'b1);

		for (int n = 0; n < 20; n++) begin
			lcg_state = next_random(lcg_state);
			tmp = lcg_state[31:20];
			start = tmp % 4001 - 2000;
			lcg_state = next_random(lcg_state);
			tmp = lcg_state[31:24];
			mag = 1 + tmp % 16;
			stride = lcg_state[16] ? -mag : mag;
			lcg_state = next_random(lcg_state);
			count = lcg_state[31:24];
			lcg_state = next_random(lcg_state);
			tmp = lcg_state[31:24];
			// Part of a stride past the last whole step adds at most one index
			bound = start + stride * count + ((stride < 0) ? -(tmp % mag) : tmp % mag);
			run_loop($sformatf("random %0d (%0d, %0d, %0d)", n, start, stride, bound),
				start, stride, bound, 1'b0, 1'b0);
		end

		wait (act_q.size() == 0);
		$display("checks: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule
